/* verilog/mcu_pkg.sv */
`default_nettype none

package mcu_pkg;

    // ************************************************************
    // widths and encodings
    // ************************************************************

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] reg_word_t;
    typedef logic [15:0] mem_word_t;
    typedef logic [31:0] mem_addr_t;
    typedef logic [8:0]  buf_index_t;
    typedef logic [8:0]  xfer_len_t;
    typedef logic [7:0]  reg_addr_t;

    typedef enum logic [1:0] {
        PHASE_CMD,
        PHASE_ADDRESS,
        PHASE_DATA,
        PHASE_NOP
    } phase_e;

    typedef enum logic [7:0] {
        CMD_IDENTIFY  = 8'd0,
        CMD_REG_READ  = 8'd1,
        CMD_REG_WRITE = 8'd2,
        CMD_MEM_READ  = 8'd3,
        CMD_MEM_WRITE = 8'd4
    } cmd_e;

    typedef enum logic [7:0] {
        REG_STATUS      = 8'd0,
        REG_MEM_ADDRESS = 8'd1,
        REG_MEM_SCR     = 8'd2
    } reg_address_e;

    localparam byte_t FPGA_ID       = 8'h64;
    localparam int    BUFFER_WORDS  = 512;
    localparam int    MEM_ADDR_STEP = 2;
    localparam int    SYNC_STAGES   = 3;

    // the MEM_SCR length field holds 1 to 512 words
    localparam int START_BIT = 0;
    localparam int STOP_BIT  = 1;
    localparam int DIR_BIT   = 2;
    localparam int BUSY_BIT  = 3;
    localparam int LEN_LSB   = 5;
    localparam int LEN_MSB   = 14;

    localparam int BUTTON_BIT = 0;
    localparam int SD_DET_BIT = 7;

    // ************************************************************
    // bundles
    // ************************************************************

    typedef struct packed {
        logic      request;
        logic      write;
        mem_addr_t address;
        mem_word_t wdata;
        logic [1:0] wmask;
    } mem_bus_req_t;

    typedef struct packed {
        logic      ack;
        mem_word_t rdata;
    } mem_bus_rsp_t;

    typedef struct packed {
        logic       read;
        logic       write;
        buf_index_t index;
        mem_word_t  wdata;
    } buf_access_t;

    // length is the word count minus one
    typedef struct packed {
        logic      start;
        logic      stop;
        logic      direction;
        xfer_len_t length;
        mem_addr_t address;
    } xfer_ctrl_t;

endpackage

`default_nettype wire

/* verilog/mcu_spi_slave.sv */
`default_nettype none

module mcu_spi_slave (
    input  logic           clk,
    input  logic           reset,
    input  logic           mcu_clk,
    input  logic           mcu_cs,
    input  logic           mcu_mosi,
    input  mcu_pkg::byte_t tx_data,
    output logic           mcu_miso,
    output logic           frame_start,
    output logic           data_ready,
    output mcu_pkg::byte_t rx_data
);

    import mcu_pkg::*;

    logic [2:0] clk_sync;
    logic [2:0] cs_sync;
    logic [1:0] mosi_sync;
    logic       clk_rise;
    logic       clk_fall;
    logic       cs_fall;
    logic       active;
    logic [2:0] bit_count;
    logic [1:0] load_delay;
    byte_t      rx_shift;
    byte_t      tx_shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            clk_sync <= '0;
            cs_sync <= '1;
        end else begin
            clk_sync <= {clk_sync[1:0], mcu_clk};
            cs_sync <= {cs_sync[1:0], mcu_cs};
        end
    end

    // same depth as the clock path so mosi lines up with the detected edge
    always_ff @(posedge clk) begin
        mosi_sync <= {mosi_sync[0], mcu_mosi};
    end

    assign clk_rise = clk_sync[1] && !clk_sync[2];
    assign clk_fall = !clk_sync[1] && clk_sync[2];
    assign cs_fall = !cs_sync[1] && cs_sync[2];
    assign active = !cs_sync[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_start <= 1'b0;
            data_ready <= 1'b0;
            load_delay <= '0;
            bit_count <= '0;
            tx_shift <= '0;
        end else begin
            frame_start <= cs_fall;
            data_ready <= 1'b0;
            load_delay <= {load_delay[0], data_ready};

            if (cs_fall) begin
                bit_count <= '0;
                tx_shift <= '0;
            end else if (active) begin
                if (clk_rise) begin
                    rx_shift <= {rx_shift[6:0], mosi_sync[1]};
                    bit_count <= bit_count + 1'b1;
                    if (bit_count == 3'd7) begin
                        data_ready <= 1'b1;
                    end
                end
                // the falling edge that closes a byte leaves the reply alone
                if (clk_fall && (bit_count != 3'd0)) begin
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end

            // the reply is taken once registered read data has settled
            if (load_delay[1]) begin
                tx_shift <= tx_data;
            end
        end
    end

    assign rx_data = rx_shift;
    assign mcu_miso = tx_shift[7];

endmodule

`default_nettype wire

/* verilog/mcu_cmd_engine.sv */
`default_nettype none

module mcu_cmd_engine (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 frame_start,
    input  logic                 data_ready,
    input  mcu_pkg::byte_t       rx_data,
    input  mcu_pkg::reg_word_t   reg_rdata,
    input  mcu_pkg::mem_word_t   mem_rdata,
    output mcu_pkg::byte_t       tx_data,
    output logic                 reg_read,
    output logic                 reg_write,
    output mcu_pkg::reg_addr_t   address,
    output mcu_pkg::reg_word_t   reg_wdata,
    output mcu_pkg::buf_access_t buf_access
);

    import mcu_pkg::*;

    phase_e     phase;
    cmd_e       cmd;
    logic [1:0] counter;
    buf_index_t buf_index;
    logic       buf_read;
    logic       buf_write;
    mem_word_t  buf_wdata;

    assign buf_access = '{
        read:  buf_read,
        write: buf_write,
        index: buf_index,
        wdata: buf_wdata
    };

    // ************************************************************
    // phase machine
    // ************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= PHASE_NOP;
            reg_read <= 1'b0;
            reg_write <= 1'b0;
            buf_read <= 1'b0;
            buf_write <= 1'b0;
        end else begin
            reg_read <= 1'b0;
            reg_write <= 1'b0;
            buf_read <= 1'b0;
            buf_write <= 1'b0;

            // both pointers step after each access they served
            if (reg_read || reg_write) begin
                address <= address + 1'b1;
            end
            if (buf_read || buf_write) begin
                buf_index <= buf_index + 1'b1;
            end

            if (frame_start) begin
                phase <= PHASE_CMD;
                counter <= '0;
            end else if (data_ready) begin
                case (phase)
                    PHASE_CMD: begin
                        cmd <= cmd_e'(rx_data);
                        if (rx_data > CMD_MEM_WRITE) begin
                            phase <= PHASE_NOP;
                        end else begin
                            phase <= PHASE_ADDRESS;
                        end
                    end

                    PHASE_ADDRESS: begin
                        address <= rx_data;
                        buf_index <= {rx_data, 1'b0};
                        phase <= PHASE_DATA;
                        reg_read <= (cmd == CMD_REG_READ);
                        buf_read <= (cmd == CMD_MEM_READ);
                    end

                    PHASE_DATA: begin
                        counter <= counter + 1'b1;
                        case (cmd)
                            CMD_REG_READ: begin
                                reg_read <= (counter == 2'd3);
                            end

                            CMD_REG_WRITE: begin
                                reg_wdata[{counter, 3'b000} +: 8] <= rx_data;
                                reg_write <= (counter == 2'd3);
                            end

                            CMD_MEM_READ: begin
                                buf_read <= counter[0];
                            end

                            CMD_MEM_WRITE: begin
                                if (counter[0]) begin
                                    buf_wdata[7:0] <= rx_data;
                                end else begin
                                    buf_wdata[15:8] <= rx_data;
                                end
                                buf_write <= counter[0];
                            end

                            default: begin
                            end
                        endcase
                    end

                    default: begin
                    end
                endcase
            end
        end
    end

    // ************************************************************
    // reply selection
    // ************************************************************

    // buffer words go out high byte first
    always_comb begin
        case (cmd)
            CMD_IDENTIFY: begin
                tx_data = FPGA_ID;
            end

            CMD_REG_READ: begin
                tx_data = reg_rdata[{counter, 3'b000} +: 8];
            end

            CMD_MEM_READ: begin
                tx_data = counter[0] ? mem_rdata[7:0] : mem_rdata[15:8];
            end

            default: begin
                tx_data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/mcu_reg_block.sv */
`default_nettype none

module mcu_reg_block (
    input  logic                clk,
    input  logic                reset,
    input  logic                reg_read,
    input  logic                reg_write,
    input  mcu_pkg::reg_addr_t  address,
    input  mcu_pkg::reg_word_t  reg_wdata,
    input  logic                busy,
    input  logic                button,
    input  logic                sd_det,
    output mcu_pkg::reg_word_t  reg_rdata,
    output mcu_pkg::xfer_ctrl_t xfer_ctrl
);

    import mcu_pkg::*;

    logic [SYNC_STAGES-1:0]   button_sync;
    logic [SYNC_STAGES-1:0]   sd_det_sync;
    logic [LEN_MSB-LEN_LSB:0] len_field;

    always_ff @(posedge clk) begin
        button_sync <= {button_sync[SYNC_STAGES-2:0], button};
        sd_det_sync <= {sd_det_sync[SYNC_STAGES-2:0], sd_det};
    end

    assign len_field = reg_wdata[LEN_MSB:LEN_LSB];

    // ************************************************************
    // register reads
    // ************************************************************

    always_ff @(posedge clk) begin
        if (reg_read) begin
            reg_rdata <= '0;
            case (address)
                REG_STATUS: begin
                    reg_rdata[BUTTON_BIT] <= button_sync[SYNC_STAGES-1];
                    reg_rdata[SD_DET_BIT] <= sd_det_sync[SYNC_STAGES-1];
                end

                REG_MEM_ADDRESS: begin
                    reg_rdata <= xfer_ctrl.address;
                end

                REG_MEM_SCR: begin
                    reg_rdata[BUSY_BIT] <= busy;
                    reg_rdata[DIR_BIT] <= xfer_ctrl.direction;
                    reg_rdata[LEN_MSB:LEN_LSB] <= {1'b0, xfer_ctrl.length} + 1'b1;
                end

                default: begin
                end
            endcase
        end
    end

    // ************************************************************
    // register writes
    // ************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            xfer_ctrl.start <= 1'b0;
            xfer_ctrl.stop <= 1'b0;
        end else begin
            xfer_ctrl.start <= 1'b0;
            xfer_ctrl.stop <= 1'b0;

            if (reg_write) begin
                case (address)
                    REG_MEM_ADDRESS: begin
                        xfer_ctrl.address <= reg_wdata;
                    end

                    // a length field of zero wraps around to 512 words
                    REG_MEM_SCR: begin
                        xfer_ctrl.start <= reg_wdata[START_BIT];
                        xfer_ctrl.stop <= reg_wdata[STOP_BIT];
                        xfer_ctrl.direction <= reg_wdata[DIR_BIT];
                        xfer_ctrl.length <= xfer_len_t'(len_field - 1'b1);
                    end

                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_transfer.sv */
`default_nettype none

module mem_transfer (
    input  logic                  clk,
    input  logic                  reset,
    input  mcu_pkg::buf_access_t  buf_access,
    input  mcu_pkg::xfer_ctrl_t   xfer_ctrl,
    input  mcu_pkg::mem_bus_rsp_t mem_rsp,
    output mcu_pkg::mem_word_t    mem_rdata,
    output logic                  busy,
    output mcu_pkg::mem_bus_req_t mem_req
);

    import mcu_pkg::*;

    mem_word_t  stage_buf [BUFFER_WORDS];
    logic       stop_pending;
    logic       req_request;
    logic       req_write;
    mem_addr_t  req_address;
    mem_word_t  req_wdata;
    buf_index_t word_index;
    xfer_len_t  last_index;
    logic       word_done;

    assign word_done = req_request && mem_rsp.ack;

    assign mem_req = '{
        request: req_request,
        write:   req_write,
        address: req_address,
        wdata:   req_wdata,
        wmask:   2'b11
    };

    // ************************************************************
    // staging buffer, SPI port and transfer port
    // ************************************************************

    always_ff @(posedge clk) begin
        if (buf_access.read) begin
            mem_rdata <= stage_buf[buf_access.index];
        end
        if (buf_access.write) begin
            stage_buf[buf_access.index] <= buf_access.wdata;
        end

        // write data is fetched on the cycle the request rises
        if (busy && !req_request) begin
            req_wdata <= stage_buf[word_index];
        end
        if (busy && word_done && !req_write) begin
            stage_buf[word_index] <= mem_rsp.rdata;
        end
    end

    // ************************************************************
    // request/ack loop
    // ************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            stop_pending <= 1'b0;
            req_request <= 1'b0;
        end else begin
            if (xfer_ctrl.stop) begin
                stop_pending <= busy;
            end else if (xfer_ctrl.start && !busy) begin
                busy <= 1'b1;
                req_write <= xfer_ctrl.direction;
                req_address <= xfer_ctrl.address;
                last_index <= xfer_ctrl.length;
                word_index <= '0;
            end

            if (busy) begin
                if (!req_request) begin
                    req_request <= 1'b1;
                end

                // request drops for a cycle between words
                if (word_done) begin
                    req_request <= 1'b0;
                    req_address <= req_address + mem_addr_t'(MEM_ADDR_STEP);
                    word_index <= word_index + 1'b1;
                    if ((word_index == last_index) || stop_pending) begin
                        busy <= 1'b0;
                        stop_pending <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/mcu_top.sv */
`default_nettype none

module mcu_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  mcu_clk,
    input  logic                  mcu_cs,
    input  logic                  mcu_mosi,
    input  logic                  button,
    input  logic                  sd_det,
    input  mcu_pkg::mem_bus_rsp_t mem_rsp,
    output logic                  mcu_miso,
    output mcu_pkg::mem_bus_req_t mem_req
);

    import mcu_pkg::*;

    logic        frame_start;
    logic        data_ready;
    byte_t       rx_data;
    byte_t       tx_data;
    logic        reg_read;
    logic        reg_write;
    reg_addr_t   address;
    reg_word_t   reg_wdata;
    reg_word_t   reg_rdata;
    mem_word_t   mem_rdata;
    buf_access_t buf_access;
    xfer_ctrl_t  xfer_ctrl;
    logic        busy;

    mcu_spi_slave spi_slave (
        .clk(clk),
        .reset(reset),
        .mcu_clk(mcu_clk),
        .mcu_cs(mcu_cs),
        .mcu_mosi(mcu_mosi),
        .tx_data(tx_data),
        .mcu_miso(mcu_miso),
        .frame_start(frame_start),
        .data_ready(data_ready),
        .rx_data(rx_data)
    );

    mcu_cmd_engine cmd_engine (
        .clk(clk),
        .reset(reset),
        .frame_start(frame_start),
        .data_ready(data_ready),
        .rx_data(rx_data),
        .reg_rdata(reg_rdata),
        .mem_rdata(mem_rdata),
        .tx_data(tx_data),
        .reg_read(reg_read),
        .reg_write(reg_write),
        .address(address),
        .reg_wdata(reg_wdata),
        .buf_access(buf_access)
    );

    mcu_reg_block reg_block (
        .clk(clk),
        .reset(reset),
        .reg_read(reg_read),
        .reg_write(reg_write),
        .address(address),
        .reg_wdata(reg_wdata),
        .busy(busy),
        .button(button),
        .sd_det(sd_det),
        .reg_rdata(reg_rdata),
        .xfer_ctrl(xfer_ctrl)
    );

    mem_transfer transfer (
        .clk(clk),
        .reset(reset),
        .buf_access(buf_access),
        .xfer_ctrl(xfer_ctrl),
        .mem_rsp(mem_rsp),
        .mem_rdata(mem_rdata),
        .busy(busy),
        .mem_req(mem_req)
    );

endmodule

`default_nettype wire

/* testbench/tb_mem_model.sv */
`default_nettype none

module tb_mem_model (
    input  logic                  clk,
    input  logic                  reset,
    input  mcu_pkg::mem_bus_req_t mem_req,
    output mcu_pkg::mem_bus_rsp_t mem_rsp
);

    timeunit 1ns;
    timeprecision 100ps;

    import mcu_pkg::*;

    localparam int MEM_WORDS = 1024;
    localparam int LOG_DEPTH = 512;

    mem_word_t   memory [MEM_WORDS];
    mem_addr_t   log_address [LOG_DEPTH];
    mem_word_t   log_data [LOG_DEPTH];
    int          write_count;
    int          read_count;
    int          range_errors;
    logic [31:0] rand_state;
    logic        pending;
    int          wait_left;
    logic [9:0]  word_addr;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // an odd multiplier spreads every bit of the byte address into the word
    function automatic mem_word_t fill_word(input int index);
        logic [31:0] byte_addr;
        byte_addr = index * 2;
        return mem_word_t'(byte_addr * 32'h0000_b5a3) ^ 16'h3c96;
    endfunction

    initial begin
        int i;
        for (i = 0; i < MEM_WORDS; i++) begin
            memory[i] = fill_word(i);
        end
        rand_state = 32'd49;
        write_count = 0;
        read_count = 0;
        range_errors = 0;
        pending = 1'b0;
        wait_left = 0;
        mem_rsp = '0;
    end

    // ************************************************************
    // the responder holds ack back 0 to 7 cycles per word
    // ************************************************************

    always begin
        @(posedge clk);
        #1;
        if (reset) begin
            mem_rsp.ack = 1'b0;
            pending = 1'b0;
        end else if (mem_rsp.ack) begin
            mem_rsp.ack = 1'b0;
        end else if (mem_req.request) begin
            if (!pending) begin
                pending = 1'b1;
                rand_state = xorshift(rand_state);
                wait_left = rand_state[2:0];
            end
            if (wait_left > 0) begin
                wait_left--;
            end else begin
                pending = 1'b0;
                mem_rsp.ack = 1'b1;
                if (mem_req.address >= mem_addr_t'(2 * MEM_WORDS)) begin
                    range_errors++;
                    mem_rsp.rdata = '0;
                    $display("memory model: access at %0d ns outside the memory, address 0x%h",
                        $time, mem_req.address);
                end else if (mem_req.write) begin
                    word_addr = mem_req.address[10:1];
                    // wmask bit 1 enables the high byte lane
                    if (mem_req.wmask[1]) begin
                        memory[word_addr][15:8] = mem_req.wdata[15:8];
                    end
                    if (mem_req.wmask[0]) begin
                        memory[word_addr][7:0] = mem_req.wdata[7:0];
                    end
                    if (write_count < LOG_DEPTH) begin
                        log_address[write_count] = mem_req.address;
                        log_data[write_count] = memory[word_addr];
                    end
                    write_count++;
                end else begin
                    mem_rsp.rdata = memory[mem_req.address[10:1]];
                    read_count++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_mcu_top.sv */
`default_nettype none

module tb_mcu_top;

    timeunit 1ns;
    timeprecision 100ps;

    import mcu_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int HALF_BIT     = 4;
    localparam int FRAME_BYTES  = 260;
    localparam int MAX_POLLS    = 24;

    localparam mem_addr_t OUT_BASE = 32'h0000_0200;
    localparam int        OUT_WORDS = 128;
    localparam mem_addr_t IN_BASE = 32'h0000_0600;
    localparam int        IN_WORDS = 16;

    // the watchdog allows twice the worst case run length in clk cycles
    localparam int BYTE_CYCLES    = 16 * HALF_BIT;
    localparam int FRAME_OVERHEAD = 32;
    localparam int TEST_BYTES     = 400 + 3 * MAX_POLLS * 6;
    localparam int TEST_FRAMES    = 20 + 3 * MAX_POLLS;
    localparam int TEST_WORDS     = OUT_WORDS + IN_WORDS + BUFFER_WORDS;
    localparam int WORD_CYCLES    = 2 + 7 + 2;
    localparam int RUN_CYCLES     = TEST_BYTES * BYTE_CYCLES + TEST_FRAMES * FRAME_OVERHEAD
                                    + TEST_WORDS * WORD_CYCLES + 200;
    localparam int WATCHDOG_NS    = 2 * RUN_CYCLES * CLK_PERIOD;

    logic         clk;
    logic         reset;
    logic         mcu_clk;
    logic         mcu_cs;
    logic         mcu_mosi;
    logic         mcu_miso;
    logic         button;
    logic         sd_det;
    mem_bus_req_t mem_req;
    mem_bus_rsp_t mem_rsp;

    byte_t       frame_tx [FRAME_BYTES];
    byte_t       frame_rx [FRAME_BYTES];
    mem_word_t   word_data [BUFFER_WORDS];
    mem_word_t   word_got [BUFFER_WORDS];
    logic [31:0] rand_state;
    int          mismatch_count;
    int          failure_count;

    mcu_top DUT (
        .clk(clk),
        .reset(reset),
        .mcu_clk(mcu_clk),
        .mcu_cs(mcu_cs),
        .mcu_mosi(mcu_mosi),
        .button(button),
        .sd_det(sd_det),
        .mem_rsp(mem_rsp),
        .mcu_miso(mcu_miso),
        .mem_req(mem_req)
    );

    tb_mem_model mem_model (
        .clk(clk),
        .reset(reset),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ************************************************************
    // helpers
    // ************************************************************

    function automatic mem_word_t random_word();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state[15:0];
    endfunction

    function automatic reg_word_t scr_word(input logic start, input logic stop,
                                           input logic dir, input int words);
        reg_word_t value;
        value = '0;
        value[START_BIT] = start;
        value[STOP_BIT] = stop;
        value[DIR_BIT] = dir;
        value[LEN_MSB:LEN_LSB] = words[LEN_MSB - LEN_LSB:0];
        return value;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected)
        else begin
            mismatch_count++;
            $display("MISMATCH at %0d ns: %s is 0x%0h, expected 0x%0h",
                $time, what, got, expected);
        end
    endtask

    task automatic check_true(input logic condition, input string what);
        assert (condition === 1'b1)
        else begin
            failure_count++;
            $display("at %0d ns: %s", $time, what);
        end
    endtask

    // every drive lands 1 ns after a rising clk edge
    task automatic idle_cycles(input int count);
        repeat (count) @(posedge clk);
        #1;
    endtask

    // mode 0 and MSB first with miso sampled on the rising mcu_clk edge
    task automatic spi_frame(input int count);
        int i;
        int b;
        mcu_cs = 1'b0;
        idle_cycles(8);
        for (i = 0; i < count; i++) begin
            for (b = 7; b >= 0; b--) begin
                mcu_mosi = frame_tx[i][b];
                idle_cycles(HALF_BIT);
                mcu_clk = 1'b1;
                frame_rx[i][b] = mcu_miso;
                idle_cycles(HALF_BIT);
                mcu_clk = 1'b0;
            end
        end
        idle_cycles(HALF_BIT);
        mcu_cs = 1'b1;
        idle_cycles(12);
    endtask

    task automatic write_register(input reg_addr_t addr, input reg_word_t value);
        frame_tx[0] = CMD_REG_WRITE;
        frame_tx[1] = addr;
        frame_tx[2] = value[7:0];
        frame_tx[3] = value[15:8];
        frame_tx[4] = value[23:16];
        frame_tx[5] = value[31:24];
        spi_frame(6);
    endtask

    // the reply to byte n comes back during byte n+1
    task automatic read_register(input reg_addr_t addr, output reg_word_t value);
        frame_tx[0] = CMD_REG_READ;
        frame_tx[1] = addr;
        frame_tx[2] = '0;
        frame_tx[3] = '0;
        frame_tx[4] = '0;
        frame_tx[5] = '0;
        spi_frame(6);
        value = {frame_rx[5], frame_rx[4], frame_rx[3], frame_rx[2]};
    endtask

    task automatic write_buffer(input reg_addr_t addr, input int count);
        int i;
        frame_tx[0] = CMD_MEM_WRITE;
        frame_tx[1] = addr;
        for (i = 0; i < count; i++) begin
            frame_tx[2 + 2 * i] = word_data[i][15:8];
            frame_tx[3 + 2 * i] = word_data[i][7:0];
        end
        spi_frame(2 + 2 * count);
    endtask

    task automatic read_buffer(input reg_addr_t addr, input int count);
        int i;
        frame_tx[0] = CMD_MEM_READ;
        frame_tx[1] = addr;
        for (i = 0; i < 2 * count; i++) begin
            frame_tx[2 + i] = '0;
        end
        spi_frame(2 + 2 * count);
        for (i = 0; i < count; i++) begin
            word_got[i] = {frame_rx[2 + 2 * i], frame_rx[3 + 2 * i]};
        end
    endtask

    task automatic wait_transfer_done();
        reg_word_t scr;
        int polls;
        polls = 0;
        read_register(REG_MEM_SCR, scr);
        while (scr[BUSY_BIT] && (polls < MAX_POLLS)) begin
            read_register(REG_MEM_SCR, scr);
            polls++;
        end
        check_true(!scr[BUSY_BIT], "the transfer never finished, busy stayed set");
    endtask

    // ************************************************************
    // test sequence
    // ************************************************************

    initial begin : main
        reg_word_t value;
        reg_word_t scr;
        int base_count;
        int words;
        int stray;
        int other_count;
        int i;
        reset = 1'b1;
        mcu_clk = 1'b0;
        mcu_cs = 1'b1;
        mcu_mosi = 1'b0;
        button = 1'b0;
        sd_det = 1'b0;
        rand_state = 32'd49;
        mismatch_count = 0;
        failure_count = 0;
        idle_cycles(RESET_CYCLES);
        reset = 1'b0;
        idle_cycles(4);

        check_true(!mem_req.request, "memory request is high after reset");
        frame_tx[0] = CMD_IDENTIFY;
        frame_tx[1] = '0;
        frame_tx[2] = '0;
        spi_frame(3);
        check_value("identify reply", frame_rx[2], FPGA_ID);

        write_register(REG_MEM_ADDRESS, 32'ha5c3_1e96);
        read_register(REG_MEM_ADDRESS, value);
        check_value("MEM_ADDRESS readback", value, 32'ha5c3_1e96);
        button = 1'b1;
        sd_det = 1'b0;
        idle_cycles(10);
        read_register(REG_STATUS, value);
        check_value("STATUS with button high", value, 32'd1 << BUTTON_BIT);
        button = 1'b0;
        sd_det = 1'b1;
        idle_cycles(10);
        read_register(REG_STATUS, value);
        check_value("STATUS with sd_det high", value, 32'd1 << SD_DET_BIT);

        // buffer words 16 to 19 through the SPI port
        for (i = 0; i < 4; i++) begin
            word_data[i] = random_word();
        end
        write_buffer(8'd8, 4);
        read_buffer(8'd8, 4);
        for (i = 0; i < 4; i++) begin
            check_value($sformatf("buffer word %0d", 16 + i), word_got[i], word_data[i]);
        end

        // buffer to bus
        for (i = 0; i < OUT_WORDS; i++) begin
            word_data[i] = random_word();
        end
        write_buffer(8'd0, OUT_WORDS);
        write_register(REG_MEM_ADDRESS, OUT_BASE);
        base_count = mem_model.write_count;
        write_register(REG_MEM_SCR, scr_word(1'b1, 1'b0, 1'b1, OUT_WORDS));
        read_register(REG_MEM_SCR, scr);
        check_true(scr[BUSY_BIT], "busy was not set while the transfer to the bus ran");
        check_value("MEM_SCR length", scr[LEN_MSB:LEN_LSB], OUT_WORDS);
        wait_transfer_done();
        check_value("bus writes logged", mem_model.write_count - base_count, OUT_WORDS);
        for (i = 0; i < OUT_WORDS; i++) begin
            check_value($sformatf("bus write %0d address", i),
                mem_model.log_address[base_count + i], OUT_BASE + 2 * i);
            check_value($sformatf("bus write %0d data", i),
                mem_model.log_data[base_count + i], word_data[i]);
        end

        // bus to buffer
        write_register(REG_MEM_ADDRESS, IN_BASE);
        base_count = mem_model.read_count;
        write_register(REG_MEM_SCR, scr_word(1'b1, 1'b0, 1'b0, IN_WORDS));
        wait_transfer_done();
        check_value("bus reads", mem_model.read_count - base_count, IN_WORDS);
        read_buffer(8'd0, IN_WORDS);
        for (i = 0; i < IN_WORDS; i++) begin
            check_value($sformatf("buffer word %0d after bus read", i), word_got[i],
                mem_model.memory[(IN_BASE >> 1) + i]);
        end

        // a full 512-word read cut short by stop
        write_register(REG_MEM_ADDRESS, 32'h0);
        base_count = mem_model.read_count;
        write_register(REG_MEM_SCR, scr_word(1'b1, 1'b0, 1'b0, BUFFER_WORDS));
        write_register(REG_MEM_SCR, scr_word(1'b0, 1'b1, 1'b0, BUFFER_WORDS));
        wait_transfer_done();
        words = mem_model.read_count - base_count;
        check_true((words > 0) && (words < BUFFER_WORDS),
            $sformatf("stop did not cut the transfer short, %0d words moved", words));
        stray = 0;
        for (i = 0; i < 64; i++) begin
            idle_cycles(1);
            if (mem_req.request) begin
                stray++;
            end
        end
        check_value("cycles with request high after stop", stray, 0);

        other_count = failure_count + mem_model.range_errors;
        $display("mismatches: %0d, other failures: %0d", mismatch_count, other_count);
        if ((mismatch_count == 0) && (other_count == 0)) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the test did not finish", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
verilog/mcu_pkg.sv
verilog/mcu_spi_slave.sv
verilog/mcu_cmd_engine.sv
verilog/mcu_reg_block.sv
verilog/mem_transfer.sv
verilog/mcu_top.sv
testbench/tb_mem_model.sv
testbench/tb_mcu_top.sv
